//--- logic/systolic_pkg.sv
package systolic_pkg;

    // word width of weights, inputs and partial sums
    localparam int data_w = 16;

    // rows and columns of the array
    localparam int array_dim = 3;

    // one signed word
    // products and sums all wrap at this width
    typedef logic signed [data_w-1:0] data_t;

    // three words, element 0 first
    // one row off the bus, or one column of a bank
    typedef data_t [array_dim-1:0] vec_t;

    // full bank contents, indexed by row
    // grid[r][c] is the word at row r, column c
    typedef vec_t [array_dim-1:0] grid_t;

    // per-row write enables, bit r selects row r
    typedef logic [array_dim-1:0] row_sel_t;

    // nine words total per bank
    // bus carries data_w * array_dim bits per cycle
    // array sizes all follow array_dim

endpackage

//--- logic/operand_bank.sv
`timescale 1ns/100ps

module operand_bank (
    input  logic                  clk,
    input  logic                  rst,
    // one enable per row
    input  systolic_pkg::row_sel_t row_we,
    // shared three-word bus
    input  systolic_pkg::vec_t     data_in,
    // registered contents, indexed by row
    output systolic_pkg::grid_t    bank
);

    import systolic_pkg::*;

    // next contents of the bank
    grid_t bank_next;

    // row load select
    // every row with its enable high takes the whole bus
    // rows with enable low hold their words
    always_comb begin
        bank_next = bank;
        for (int r = 0; r < array_dim; r++) begin
            if (row_we[r]) begin
                // all three columns of the row at once
                bank_next[r] = data_in;
            end
        end
    end

    // bank storage
    // cleared so the array computes a zero sum after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            bank <= '0;
        end else begin
            bank <= bank_next;
        end
    end

    // write in cycle t is visible from cycle t+1
    // several rows may load in the same cycle
    // no read port, contents are always visible to the columns
    // same module serves weights and inputs

endmodule

//--- logic/pe_column.sv
`timescale 1ns/100ps

module pe_column (
    input  logic               clk,
    input  logic               rst,
    // weights of this column, element r from row r
    input  systolic_pkg::vec_t weight,
    // inputs of this column, element r from row r
    input  systolic_pkg::vec_t operand,
    // bottom partial sum of the column
    output systolic_pkg::data_t col_sum
);

    import systolic_pkg::*;

    // low 16 bits of each row's product
    data_t [array_dim-1:0] prod;

    // partial sum entering each row from above
    data_t [array_dim-1:0] sum_in;

    // multiply-add result of each row before the register
    data_t [array_dim-1:0] mac;

    // registered partial sums, one per row
    data_t [array_dim-1:0] stage;

    // products
    // result width is data_w so the upper half is dropped
    always_comb begin
        for (int r = 0; r < array_dim; r++) begin
            prod[r] = weight[r] * operand[r];
        end
    end

    // partial sum chain
    // top element starts from zero
    // every lower element takes the registered sum one row up
    always_comb begin
        sum_in[0] = '0;
        for (int r = 1; r < array_dim; r++) begin
            sum_in[r] = stage[r-1];
        end
    end

    // add the product to the incoming partial sum
    // wraps on overflow, no saturation
    always_comb begin
        for (int r = 0; r < array_dim; r++) begin
            mac[r] = prod[r] + sum_in[r];
        end
    end

    // stage registers
    // sums move down one row per cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            stage <= '0;
        end else begin
            for (int r = 0; r < array_dim; r++) begin
                stage[r] <= mac[r];
            end
        end
    end

    // bottom register leaves the column
    // row 0 product reaches it after three cycles
    assign col_sum = stage[array_dim-1];

    // stage0(t+1) = P0(t)
    // stage1(t+1) = stage0(t) + P1(t)
    // col_sum(t+1) = stage1(t) + P2(t)
    // weights and inputs are static here

endmodule

//--- logic/column_reducer.sv
`timescale 1ns/100ps

module column_reducer (
    input  logic                clk,
    input  logic                rst,
    // bottom sums of the three columns
    input  systolic_pkg::data_t col_sum_0,
    input  systolic_pkg::data_t col_sum_1,
    input  systolic_pkg::data_t col_sum_2,
    // final dot product
    output systolic_pkg::data_t result
);

    import systolic_pkg::*;

    // first level, columns 0 and 1
    data_t pair_sum;

    // registered first level
    data_t partial;

    // second level, adds column 2
    data_t total_sum;

    // both additions wrap at data_w bits
    assign pair_sum  = col_sum_0 + col_sum_1;
    assign total_sum = partial + col_sum_2;

    // two register stages
    // column 2 joins one cycle after columns 0 and 1
    always_ff @(posedge clk) begin
        if (rst) begin
            partial <= '0;
            result  <= '0;
        end else begin
            partial <= pair_sum;
            result  <= total_sum;
        end
    end

    // partial(t+1) = col_sum_0(t) + col_sum_1(t)
    // result(t+1) = partial(t) + col_sum_2(t)
    // result is a register, no output scaling
    // zero right after reset since every column is cleared too

endmodule

//--- logic/systolic_array.sv
`timescale 1ns/100ps

module systolic_array (
    input  logic                   clk,
    input  logic                   rst,
    // shared word bus for both banks
    input  systolic_pkg::vec_t     data_in,
    // row writes into the weight bank
    input  systolic_pkg::row_sel_t weight_row_we,
    // row writes into the input bank
    input  systolic_pkg::row_sel_t input_row_we,
    // settled nine-term dot product
    output systolic_pkg::data_t    result
);

    import systolic_pkg::*;

    // bank contents, indexed by row
    grid_t weight_grid;
    grid_t input_grid;

    // same contents regrouped by column
    // weight_cols[c][r] is row r of column c
    grid_t weight_cols;
    grid_t input_cols;

    // bottom sums of each column
    data_t col_sum_0;
    data_t col_sum_1;
    data_t col_sum_2;

    // weights stay put once written
    operand_bank weight_bank (
        .clk     (clk),
        .rst     (rst),
        .row_we  (weight_row_we),
        .data_in (data_in),
        .bank    (weight_grid)
    );

    // input words, written from the same bus
    operand_bank input_bank (
        .clk     (clk),
        .rst     (rst),
        .row_we  (input_row_we),
        .data_in (data_in),
        .bank    (input_grid)
    );

    // transpose rows into columns
    // pure wiring, no logic
    for (genvar c = 0; c < array_dim; c++) begin : g_col_slice
        for (genvar r = 0; r < array_dim; r++) begin : g_row_slice
            assign weight_cols[c][r] = weight_grid[r][c];
            assign input_cols[c][r]  = input_grid[r][c];
        end
    end

    // column 0
    pe_column column_0 (
        .clk     (clk),
        .rst     (rst),
        .weight  (weight_cols[0]),
        .operand (input_cols[0]),
        .col_sum (col_sum_0)
    );

    // column 1
    pe_column column_1 (
        .clk     (clk),
        .rst     (rst),
        .weight  (weight_cols[1]),
        .operand (input_cols[1]),
        .col_sum (col_sum_1)
    );

    // column 2
    // its sum enters the reducer one level later
    pe_column column_2 (
        .clk     (clk),
        .rst     (rst),
        .weight  (weight_cols[2]),
        .operand (input_cols[2]),
        .col_sum (col_sum_2)
    );

    // two-stage fold of the column sums
    column_reducer reducer (
        .clk       (clk),
        .rst       (rst),
        .col_sum_0 (col_sum_0),
        .col_sum_1 (col_sum_1),
        .col_sum_2 (col_sum_2),
        .result    (result)
    );

    // write at t, bank holds it from t+1
    // three column stages plus two reducer stages
    // result settled 5 cycles after the last write takes effect
    // new writes may follow every cycle, sets overlap in the pipe
    // no handshake, nothing stalls

endmodule

//--- bench/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // reset held for 10 rising edges, released just after the edge
    initial begin
        rst = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

//--- bench/systolic_array_sva.sv
`timescale 1ns/100ps

module systolic_array_sva (
    input logic                   clk,
    input logic                   rst,
    input systolic_pkg::vec_t     data_in,
    input systolic_pkg::row_sel_t weight_row_we,
    input systolic_pkg::row_sel_t input_row_we,
    input systolic_pkg::data_t    result
);

    import systolic_pkg::*;

    // count of failed assertions
    int fail_count = 0;

    // shadow banks rebuilt from the port history
    grid_t w_sh;
    grid_t x_sh;

    // shadow column stages, indexed by column
    data_t [array_dim-1:0] st0;
    data_t [array_dim-1:0] st1;
    data_t [array_dim-1:0] cs;

    // shadow reducer
    data_t part;
    data_t res_sh;

    // set once any row has been written
    logic written;

    // low half of the signed product
    function automatic data_t product_low(input data_t w, input data_t x);
        logic signed [31:0] full;
        full = 32'(w) * 32'(x);
        return data_t'(full[15:0]);
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            w_sh    <= '0;
            x_sh    <= '0;
            st0     <= '0;
            st1     <= '0;
            cs      <= '0;
            part    <= '0;
            res_sh  <= '0;
            written <= 1'b0;
        end else begin
            for (int r = 0; r < array_dim; r++) begin
                if (weight_row_we[r]) w_sh[r] <= data_in;
                if (input_row_we[r]) x_sh[r] <= data_in;
            end
            // each row joins its column one cycle after the row above
            for (int c = 0; c < array_dim; c++) begin
                st0[c] <= product_low(w_sh[0][c], x_sh[0][c]);
                st1[c] <= st0[c] + product_low(w_sh[1][c], x_sh[1][c]);
                cs[c]  <= st1[c] + product_low(w_sh[2][c], x_sh[2][c]);
            end
            // column 2 joins one level later
            part   <= cs[0] + cs[1];
            res_sh <= part + cs[2];
            if (|weight_row_we || |input_row_we) written <= 1'b1;
        end
    end

    // cleared right after reset release
    assert property (@(posedge clk) $fell(rst) |-> result == '0)
        else begin
            fail_count++;
            $error("ERROR result expected 0000 actual %h after reset release",
                   $sampled(result));
        end

    // nothing written yet so nothing to sum
    assert property (@(posedge clk) disable iff (rst) !written |-> result == '0)
        else begin
            fail_count++;
            $error("ERROR result expected 0000 actual %h before any write", $sampled(result));
        end

    // every cycle against the skewed pipeline
    assert property (@(posedge clk) disable iff (rst) result == res_sh)
        else begin
            fail_count++;
            $error("ERROR result expected %h actual %h", $sampled(res_sh), $sampled(result));
        end

endmodule

bind systolic_array systolic_array_sva sva_check (
    .clk           (clk),
    .rst           (rst),
    .data_in       (data_in),
    .weight_row_we (weight_row_we),
    .input_row_we  (input_row_we),
    .result        (result)
);

//--- bench/systolic_array_tb.sv
`timescale 1ns/100ps

module systolic_array_tb;

    import systolic_pkg::*;

    // phase lengths in cycles
    localparam int reset_len  = 16;
    localparam int dot_rounds = 4;
    localparam int dot_len    = dot_rounds * 12;
    localparam int select_len = 3 * 10 + 9;
    localparam int skew_cycles = 200;
    localparam int skew_len   = skew_cycles + 6;
    localparam int wrap_len   = 3 * 12;
    localparam int timeout_limit =
        reset_len + dot_len + select_len + skew_len + wrap_len + 50;

    logic     clk;
    logic     rst;
    vec_t     data_in;
    row_sel_t weight_row_we;
    row_sel_t input_row_we;
    data_t    result;

    // model of both banks, updated as rows are driven
    grid_t w_model;
    grid_t x_model;

    logic [31:0] lfsr_state = 32'h292c_6dcd;
    int cycle_count = 0;
    int check_count = 0;
    int error_count = 0;
    int total_errors;

    tb_clock_gen clock_gen (
        .clk (clk),
        .rst (rst)
    );

    systolic_array dut (
        .clk           (clk),
        .rst           (rst),
        .data_in       (data_in),
        .weight_row_we (weight_row_we),
        .input_row_we  (input_row_we),
        .result        (result)
    );

    // galois form, right shift
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) return (s >> 1) ^ 32'h8020_0003;
        return s >> 1;
    endfunction

    // one lfsr step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic vec_t random_word();
        vec_t w;
        for (int c = 0; c < array_dim; c++) begin
            w[c] = data_t'(take_bits(16));
        end
        return w;
    endfunction

    // operands near the signed limits, idx = 3*row + col
    function automatic data_t limit_word(input int set, input int idx, input bit is_weight);
        case (set)
            0: return is_weight ? data_t'(16'h8000 + idx) : data_t'(16'h7fff - idx);
            1: return is_weight ? data_t'(16'h7fff - idx) : data_t'(16'h7ff0 + idx);
            default: return is_weight ? data_t'(16'hffff - idx) : data_t'(16'h8000 + idx);
        endcase
    endfunction

    // nine products, low halves summed, mod 2^16
    function automatic data_t dot_expected();
        logic signed [31:0] full;
        logic [15:0] acc;
        acc = '0;
        for (int r = 0; r < array_dim; r++) begin
            for (int c = 0; c < array_dim; c++) begin
                full = 32'(w_model[r][c]) * 32'(x_model[r][c]);
                acc = acc + full[15:0];
            end
        end
        return data_t'(acc);
    endfunction

    // one cycle on the bus, enables as given
    task automatic write_row(input vec_t word, input row_sel_t wwe, input row_sel_t iwe);
        data_in = word;
        weight_row_we = wwe;
        input_row_we = iwe;
        for (int r = 0; r < array_dim; r++) begin
            if (wwe[r]) w_model[r] = word;
            if (iwe[r]) x_model[r] = word;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic hold_idle(input int cycles);
        weight_row_we = '0;
        input_row_we = '0;
        repeat (cycles) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic check_settled(input string what);
        data_t exp;
        exp = dot_expected();
        check_count++;
        if (result !== exp) begin
            error_count++;
            $display("ERROR %s: result expected %h actual %h", what, exp, result);
        end
    endtask

    // stops a stuck run
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            $display("timeout: run still going after %0d cycles", cycle_count);
            $display("Test failures found");
            $finish;
        end
    end

    initial begin
        data_in = '0;
        weight_row_we = '0;
        input_row_we = '0;
        w_model = '0;
        x_model = '0;
        @(posedge clk);
        while (rst) @(posedge clk);
        #1;

        // reset: result stays zero with no writes
        hold_idle(4);
        check_settled("reset");

        // full loads, then settle
        for (int n = 0; n < dot_rounds; n++) begin
            for (int r = 0; r < array_dim; r++) begin
                write_row(random_word(), row_sel_t'(1 << r), '0);
            end
            for (int r = 0; r < array_dim; r++) begin
                write_row(random_word(), '0, row_sel_t'(1 << r));
            end
            hold_idle(6);
            check_settled("dot product");
        end

        // only row k has nonzero inputs, then only weight row k rewritten
        for (int k = 0; k < array_dim; k++) begin
            for (int r = 0; r < array_dim; r++) begin
                if (r == k) write_row(random_word(), '0, row_sel_t'(1 << r));
                else write_row('0, '0, row_sel_t'(1 << r));
            end
            write_row(random_word(), row_sel_t'(1 << k), '0);
            hold_idle(6);
            check_settled("row select");
        end
        // fresh inputs expose any weight row that changed unasked
        for (int r = 0; r < array_dim; r++) begin
            write_row(random_word(), '0, row_sel_t'(1 << r));
        end
        hold_idle(6);
        check_settled("kept rows");

        // writes every cycle, several sets in flight
        for (int n = 0; n < skew_cycles; n++) begin
            write_row(random_word(), row_sel_t'(take_bits(3)), row_sel_t'(take_bits(3)));
        end
        hold_idle(6);
        check_settled("pipelined skew");

        // products and sums that overflow 16 bits
        for (int s = 0; s < 3; s++) begin
            for (int r = 0; r < array_dim; r++) begin
                vec_t wv;
                vec_t xv;
                for (int c = 0; c < array_dim; c++) begin
                    wv[c] = limit_word(s, 3 * r + c, 1'b1);
                    xv[c] = limit_word(s, 3 * r + c, 1'b0);
                end
                write_row(wv, row_sel_t'(1 << r), '0);
                write_row(xv, '0, row_sel_t'(1 << r));
            end
            hold_idle(6);
            check_settled("signed wrap");
        end

        total_errors = error_count + dut.sva_check.fail_count;
        $display("checks %0d, settled errors %0d, assertion errors %0d",
                 check_count, error_count, dut.sva_check.fail_count);
        if (total_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- src.f
logic/systolic_pkg.sv
logic/operand_bank.sv
logic/pe_column.sv
logic/column_reducer.sv
logic/systolic_array.sv
bench/tb_clock_gen.sv
bench/systolic_array_sva.sv
bench/systolic_array_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run with Verilator from the project root
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module systolic_array_tb -f src.f \
    > build.log 2>&1 \
    || { echo 'build failed, see build.log'; exit 1; }

./obj_dir/Vsystolic_array_tb > sim.log 2>&1 \
    || { echo 'simulation exited with an error, see sim.log'; exit 1; }

grep -q 'Test failures found' sim.log \
    && { echo 'simulation reported failures, see sim.log'; exit 1; }

grep -q 'All tests passed!' sim.log \
    || { echo 'simulation ended without a result, see sim.log'; exit 1; }

echo 'simulation passed'
